//--- Bender.yml
package:
  name: csa_feed

sources:
  - files:
      - hdl/csa_feed_pkg.sv
      - hdl/word_fifo.sv
      - hdl/axil_word_port.sv
      - hdl/convert_32_to_40.sv
      - hdl/csa_feed_top.sv
  - target: test
    files:
      - dv/csa_feed_tb.sv

//--- dv/csa_feed_tb.sv
`timescale 1ns/1ps

module csa_feed_tb;

	localparam int block_bits = csa_feed_pkg::words_per_block * csa_feed_pkg::word_width;

	logic        clk = 1'b0;
	logic        rst_n;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic [39:0] rd_data;
	logic        rd_valid;
	logic        rd_ready;

	int                    seed = 33;
	logic [31:0]           pending_words [$]; // Words of the block being gathered.
	logic [39:0]           expected_lanes [$];
	int                    burst_len;
	int                    tries;
	bit                    ok;
	bit                    stalled;
	logic [31:0]           word;
	logic [31:0]           rnd;
	logic [31:0]           rd_word;
	logic [1:0]            resp;
	csa_feed_pkg::status_t status;

	csa_feed_top dut (.*);

	always #10 clk = ~clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_equal(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		assert (got === exp) else
			fail_run($sformatf("CHECK FAILED at %0t: %s is %0h, expected %0h",
				$time, name, got, exp));
	endtask

	// Block bits follow the word order and lanes are cut from the same bits.
	task automatic record_word(input logic [31:0] data);
		logic [block_bits-1:0] bits;
		pending_words.push_back(data);
		if (pending_words.size() == csa_feed_pkg::words_per_block) begin
			for (int i = 0; i < csa_feed_pkg::words_per_block; i++) begin
				bits[32*i +: 32] = pending_words.pop_front();
			end
			for (int k = 0; k < csa_feed_pkg::lanes_per_block; k++) begin
				expected_lanes.push_back(bits[40*k +: 40]);
			end
		end
	endtask

	task automatic start_write(input logic [3:0] addr, input logic [31:0] data);
		@(posedge clk);
		awaddr  <= addr;
		wdata   <= data;
		wstrb   <= 4'hf;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		bready  <= 1'b1;
	endtask

	task automatic wait_write_accept(input int limit, output bit accepted);
		int n;
		n = 0;
		accepted = 1'b0;
		while (!accepted && n < limit) begin
			@(negedge clk);
			accepted = awready && wready;
			n++;
		end
	endtask

	task automatic finish_write(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] wr_resp);
		int n;
		n = 0;
		@(posedge clk); // Accepting edge.
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		if (addr == csa_feed_pkg::addr_data) begin
			record_word(data);
		end
		do begin
			@(negedge clk);
			n++;
		end while (!bvalid && n < 20);
		assert (bvalid) else fail_run("Write response timed out, bvalid never rose.");
		wr_resp = bresp;
		@(posedge clk);
		bready <= 1'b0;
	endtask

	task automatic write_word(input logic [3:0] addr, input logic [31:0] data,
			input logic [1:0] exp_resp);
		bit          accepted;
		logic [1:0]  wr_resp;
		start_write(addr, data);
		wait_write_accept(100, accepted);
		assert (accepted) else fail_run("Write handshake timed out, awready never rose.");
		finish_write(addr, data, wr_resp);
		check_equal("bresp", wr_resp, exp_resp);
	endtask

	task automatic read_reg(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] rd_resp);
		int n;
		n = 0;
		@(posedge clk);
		araddr  <= addr;
		arvalid <= 1'b1;
		rready  <= 1'b1;
		do begin
			@(negedge clk);
			n++;
		end while (!arready && n < 20);
		assert (arready) else fail_run("Read address handshake timed out.");
		@(posedge clk);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (!rvalid && n < 20);
		assert (rvalid) else fail_run("Read data timed out, rvalid never rose.");
		data    = rdata;
		rd_resp = rresp;
		@(posedge clk);
		rready <= 1'b0;
	endtask

	task automatic wait_drain(input int limit);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while ((expected_lanes.size() != 0 || rd_valid) && n < limit);
		assert (expected_lanes.size() == 0 && !rd_valid) else
			fail_run("Lane stream did not drain in time.");
	endtask

	// Lane taken at the coming edge when valid and ready are both high.
	always @(negedge clk) begin
		if (rst_n && rd_valid && rd_ready) begin
			assert (expected_lanes.size() != 0) else
				fail_run("A lane came out that no written block accounts for.");
			check_equal("rd_data", rd_data, expected_lanes.pop_front());
		end
	end

	initial begin
		rst_n    = 1'b0;
		awaddr   = '0;
		awvalid  = 1'b0;
		wdata    = '0;
		wstrb    = '0;
		wvalid   = 1'b0;
		bready   = 1'b0;
		araddr   = '0;
		arvalid  = 1'b0;
		rready   = 1'b0;
		rd_ready = 1'b0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// Idle state after reset.
		@(negedge clk);
		check_equal("rd_valid", rd_valid, 0);
		check_equal("bvalid", bvalid, 0);
		read_reg(csa_feed_pkg::addr_status, rd_word, resp);
		check_equal("status", rd_word, 0);
		check_equal("rresp", resp, csa_feed_pkg::resp_okay);

		// Straight packing with the consumer always ready.
		@(posedge clk);
		rd_ready <= 1'b1;
		for (int i = 0; i < 40; i++) begin
			word = $random(seed);
			write_word(csa_feed_pkg::addr_data, word, csa_feed_pkg::resp_okay);
		end
		wait_drain(200);

		// Fill everything with the consumer stopped.
		@(posedge clk);
		rd_ready <= 1'b0;
		stalled = 1'b0;
		tries = 0;
		while (!stalled && tries < 40) begin
			word = $random(seed);
			start_write(csa_feed_pkg::addr_data, word);
			wait_write_accept(30, ok);
			if (ok) begin
				finish_write(csa_feed_pkg::addr_data, word, resp);
				check_equal("bresp", resp, csa_feed_pkg::resp_okay);
			end else begin
				stalled = 1'b1;
			end
			tries++;
		end
		assert (stalled) else fail_run("Writes never stalled with the lane output blocked.");
		read_reg(csa_feed_pkg::addr_status, rd_word, resp);
		status = rd_word;
		check_equal("status.in_full", status.in_full, 1);
		check_equal("status.out_count", status.out_count, 8);
		check_equal("status.in_count", status.in_count, 16);
		@(posedge clk);
		rd_ready <= 1'b1;
		wait_write_accept(200, ok);
		assert (ok) else fail_run("Stalled write never completed after the output was freed.");
		finish_write(csa_feed_pkg::addr_data, word, resp);
		check_equal("bresp", resp, csa_feed_pkg::resp_okay);
		wait_drain(500);

		// Bursts against a randomly stalling consumer.
		for (int b = 0; b < 10; b++) begin
			rnd = $random(seed);
			burst_len = 1 + (rnd[3:0] % 12);
			for (int i = 0; i < burst_len; i++) begin
				rnd = $random(seed);
				@(posedge clk);
				rd_ready <= rnd[0];
				word = $random(seed);
				write_word(csa_feed_pkg::addr_data, word, csa_feed_pkg::resp_okay);
			end
			@(posedge clk);
			rd_ready <= 1'b1;
			wait_drain(300);
		end

		// Unmapped accesses leave the stream alone.
		// An open block would shift its lanes if a stray word got pushed.
		if (pending_words.size() == 0) begin
			word = $random(seed);
			write_word(csa_feed_pkg::addr_data, word, csa_feed_pkg::resp_okay);
		end
		write_word(4'h8, 32'hdead_beef, csa_feed_pkg::resp_slverr);
		write_word(csa_feed_pkg::addr_status, 32'h1234_5678, csa_feed_pkg::resp_slverr);
		read_reg(4'hc, rd_word, resp);
		check_equal("rdata", rd_word, 0);
		check_equal("rresp", resp, csa_feed_pkg::resp_slverr);
		while (pending_words.size() != 0) begin
			word = $random(seed);
			write_word(csa_feed_pkg::addr_data, word, csa_feed_pkg::resp_okay);
		end
		wait_drain(200);

		// A partial block stays inside until it is completed.
		for (int i = 0; i < 3; i++) begin
			word = $random(seed);
			write_word(csa_feed_pkg::addr_data, word, csa_feed_pkg::resp_okay);
		end
		repeat (20) begin
			@(negedge clk);
			check_equal("rd_valid", rd_valid, 0);
		end
		read_reg(csa_feed_pkg::addr_status, rd_word, resp);
		status = rd_word;
		check_equal("in_count + pending", status.in_count + pending_words.size(), 3);
		for (int i = 0; i < 2; i++) begin
			word = $random(seed);
			write_word(csa_feed_pkg::addr_data, word, csa_feed_pkg::resp_okay);
		end
		wait_drain(200);

		if (expected_lanes.size() == 0 && pending_words.size() == 0) begin
			$display("Simulation PASSED");
			$finish;
		end else begin
			fail_run("Model still holds words or lanes at the end of the run.");
		end
	end

endmodule

//--- hdl/axil_word_port.sv
`timescale 1ns/1ps

module axil_word_port (
	input  logic                                                   clk,
	input  logic                                                   rst_n,

	input  logic [3:0]                                             awaddr,
	input  logic                                                   awvalid,
	output logic                                                   awready,

	input  logic [csa_feed_pkg::word_width-1:0]                    wdata,
	input  logic [3:0]                                             wstrb,
	input  logic                                                   wvalid,
	output logic                                                   wready,

	output logic [1:0]                                             bresp,
	output logic                                                   bvalid,
	input  logic                                                   bready,

	input  logic [3:0]                                             araddr,
	input  logic                                                   arvalid,
	output logic                                                   arready,

	output logic [csa_feed_pkg::word_width-1:0]                    rdata,
	output logic [1:0]                                             rresp,
	output logic                                                   rvalid,
	input  logic                                                   rready,

	output logic                                                   in_push,
	output logic [csa_feed_pkg::word_width-1:0]                    in_data,
	input  logic                                                   in_full,
	input  logic [$clog2(csa_feed_pkg::in_fifo_depth + 1)-1:0]     in_count,
	input  logic [$clog2(csa_feed_pkg::out_fifo_depth + 1)-1:0]    out_count
);

	logic                  wr_is_data;
	logic                  wr_accept;
	logic                  rd_accept;
	csa_feed_pkg::status_t status_word;

	assign wr_is_data = (awaddr == csa_feed_pkg::addr_data);

	// Address and data are taken together, and a data write waits for FIFO room.
	assign wr_accept = awvalid && wvalid && !bvalid && (!wr_is_data || !in_full);
	assign awready   = wr_accept;
	assign wready    = wr_accept;

	// Byte strobes play no part and the whole word goes into the FIFO.
	assign in_push = wr_accept && wr_is_data;
	assign in_data = wdata;

	assign rd_accept = arvalid && !rvalid;
	assign arready   = rd_accept;

	always_comb begin
		status_word           = '0;
		status_word.in_count  = in_count;
		status_word.out_count = out_count;
		status_word.in_full   = in_full;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bvalid <= 1'b0;
		end else if (wr_accept) begin
			bvalid <= 1'b1;
		end else if (bready) begin
			bvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_accept) begin
			bresp <= wr_is_data ? csa_feed_pkg::resp_okay : csa_feed_pkg::resp_slverr;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rvalid <= 1'b0;
		end else if (rd_accept) begin
			rvalid <= 1'b1;
		end else if (rready) begin
			rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			if (araddr == csa_feed_pkg::addr_status) begin
				rdata <= status_word;
				rresp <= csa_feed_pkg::resp_okay;
			end else begin
				rdata <= '0; // Unmapped reads return zero.
				rresp <= csa_feed_pkg::resp_slverr;
			end
		end
	end

endmodule

//--- hdl/convert_32_to_40.sv
`timescale 1ns/1ps

module convert_32_to_40 (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 in_empty,
	input  logic [csa_feed_pkg::word_width-1:0]  in_word,
	output logic                                 in_pop,
	input  logic                                 out_full,
	output logic                                 out_push,
	output logic [csa_feed_pkg::lane_width-1:0]  out_lane
);

	localparam int word_idx_width = $clog2(csa_feed_pkg::words_per_block);
	localparam int lane_idx_width = $clog2(csa_feed_pkg::lanes_per_block);

	localparam logic [word_idx_width-1:0] last_word =
		word_idx_width'(csa_feed_pkg::words_per_block - 1);
	localparam logic [lane_idx_width-1:0] last_lane =
		lane_idx_width'(csa_feed_pkg::lanes_per_block - 1);

	logic                       emit;     // Low while gathering, high while emitting.
	logic [word_idx_width-1:0]  word_idx;
	logic [lane_idx_width-1:0]  lane_idx;
	csa_feed_pkg::block_u       block;

	// One word per cycle while gathering and the input has data.
	assign in_pop = !emit && !in_empty;

	// One lane per cycle while emitting, held off by a full output FIFO.
	assign out_push = emit && !out_full;
	assign out_lane = block.lanes[lane_idx];

	always_ff @(posedge clk) begin
		if (in_pop) begin
			block.words[word_idx] <= in_word;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			emit     <= 1'b0;
			word_idx <= '0;
			lane_idx <= '0;
		end else if (!emit) begin
			if (in_pop) begin
				if (word_idx == last_word) begin
					word_idx <= '0;
					emit     <= 1'b1; // Block complete.
				end else begin
					word_idx <= word_idx + 1'b1;
				end
			end
		end else begin
			if (out_push) begin
				if (lane_idx == last_lane) begin
					lane_idx <= '0;
					emit     <= 1'b0; // Back to gathering.
				end else begin
					lane_idx <= lane_idx + 1'b1;
				end
			end
		end
	end

endmodule

//--- hdl/csa_feed_pkg.sv
package csa_feed_pkg;

	localparam int word_width      = 32;
	localparam int lane_width      = 40;
	localparam int words_per_block = 5;
	localparam int lanes_per_block = 4;

	localparam int in_fifo_depth  = 16;
	localparam int out_fifo_depth = 8;

	// Byte addresses on the 4-bit AXI4-Lite address bus.
	localparam logic [3:0] addr_data   = 4'h0;
	localparam logic [3:0] addr_status = 4'h4;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// One 160-bit block, filled as host words and drained as operand lanes.
	typedef union packed {
		logic [words_per_block-1:0][word_width-1:0] words; // Word i at bits 32i up.
		logic [lanes_per_block-1:0][lane_width-1:0] lanes; // Lane k at bits 40k up.
	} block_u;

	typedef struct packed {
		logic [21:0] reserved;
		logic [4:0]  in_count;  // Words waiting in the input FIFO.
		logic [3:0]  out_count; // Lanes waiting in the output FIFO.
		logic        in_full;
	} status_t;

endpackage

//--- hdl/csa_feed_top.sv
`timescale 1ns/1ps

module csa_feed_top (
	input  logic                                 clk,
	input  logic                                 rst_n,

	input  logic [3:0]                           awaddr,
	input  logic                                 awvalid,
	output logic                                 awready,
	input  logic [csa_feed_pkg::word_width-1:0]  wdata,
	input  logic [3:0]                           wstrb,
	input  logic                                 wvalid,
	output logic                                 wready,
	output logic [1:0]                           bresp,
	output logic                                 bvalid,
	input  logic                                 bready,
	input  logic [3:0]                           araddr,
	input  logic                                 arvalid,
	output logic                                 arready,
	output logic [csa_feed_pkg::word_width-1:0]  rdata,
	output logic [1:0]                           rresp,
	output logic                                 rvalid,
	input  logic                                 rready,

	output logic [csa_feed_pkg::lane_width-1:0]  rd_data,
	output logic                                 rd_valid,
	input  logic                                 rd_ready
);

	logic                                                  in_push;
	logic [csa_feed_pkg::word_width-1:0]                   in_data;
	logic [csa_feed_pkg::word_width-1:0]                   in_head;
	logic                                                  in_pop;
	logic                                                  in_empty;
	logic                                                  in_full;
	logic [$clog2(csa_feed_pkg::in_fifo_depth + 1)-1:0]    in_count;

	logic                                                  out_push;
	logic [csa_feed_pkg::lane_width-1:0]                   out_lane;
	logic                                                  out_empty;
	logic                                                  out_full;
	logic [$clog2(csa_feed_pkg::out_fifo_depth + 1)-1:0]   out_count;

	assign rd_valid = !out_empty;

	axil_word_port u_port (
		.clk, .rst_n,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.in_push, .in_data, .in_full, .in_count, .out_count
	);

	word_fifo #(
		.width (csa_feed_pkg::word_width),
		.depth (csa_feed_pkg::in_fifo_depth)
	) in_fifo (
		.clk, .rst_n,
		.push      (in_push),
		.push_data (in_data),
		.pop       (in_pop),
		.head      (in_head),
		.empty     (in_empty),
		.full      (in_full),
		.count     (in_count)
	);

	convert_32_to_40 u_convert (
		.clk, .rst_n,
		.in_empty, .in_word (in_head), .in_pop,
		.out_full, .out_push, .out_lane
	);

	word_fifo #(
		.width (csa_feed_pkg::lane_width),
		.depth (csa_feed_pkg::out_fifo_depth)
	) out_fifo (
		.clk, .rst_n,
		.push      (out_push),
		.push_data (out_lane),
		.pop       (rd_ready),
		.head      (rd_data),
		.empty     (out_empty),
		.full      (out_full),
		.count     (out_count)
	);

endmodule

//--- hdl/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
	parameter int width = 32,
	parameter int depth = 16
) (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         push,
	input  logic [width-1:0]             push_data,
	input  logic                         pop,
	output logic [width-1:0]             head,
	output logic                         empty,
	output logic                         full,
	output logic [$clog2(depth+1)-1:0]   count
);

	localparam int ptr_width = $clog2(depth);

	logic [width-1:0]     mem [depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic                 do_push;
	logic                 do_pop;

	assign empty = (count == '0);
	assign full  = (count == ($clog2(depth+1))'(depth));

	assign do_push = push && !full;  // Push into a full FIFO is dropped.
	assign do_pop  = pop && !empty;  // Pop of an empty FIFO is dropped.

	assign head = mem[rd_ptr]; // Show-ahead head word.

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				if (wr_ptr == ptr_width'(depth - 1)) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (do_pop) begin
				if (rd_ptr == ptr_width'(depth - 1)) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // Both or neither keep the level.
			endcase
		end
	end

endmodule

//--- sim.f
hdl/csa_feed_pkg.sv
hdl/word_fifo.sv
hdl/axil_word_port.sv
hdl/convert_32_to_40.sv
hdl/csa_feed_top.sv
dv/csa_feed_tb.sv
